/* hdl/busy_table.sv */
//////////////////////////////////////////////////
// Busy table
// One busy bit per physical register, set at
// dispatch, cleared at writeback, emptied by flush
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "prf_params.svh"

module busy_table (
  input  logic                                      clock,
  input  logic                                      rst_n,
  input  logic                                      flush,
  input  prf_pkg::prf_index_t [`DISPATCH_WIDTH-1:0] set_index,
  input  logic [`DISPATCH_WIDTH-1:0]                set_valid,
  input  prf_pkg::prf_index_t [`PRF_WAYS-1:0]       clear_index,
  input  prf_pkg::wb_valid_t                        clear_valid,
  input  iq_pkg::int_index_vec_t                    rs1_int_index,
  input  iq_pkg::int_index_vec_t                    rs2_int_index,
  input  iq_pkg::mem_index_vec_t                    rs1_mem_index,
  input  iq_pkg::mem_index_vec_t                    rs2_mem_index,
  output iq_pkg::int_slot_mask_t                    rs1_int_table,
  output iq_pkg::int_slot_mask_t                    rs2_int_table,
  output iq_pkg::mem_slot_mask_t                    rs1_mem_table,
  output iq_pkg::mem_slot_mask_t                    rs2_mem_table
);

  prf_pkg::prf_mask_t busy_q;
  prf_pkg::prf_mask_t busy_d;
  prf_pkg::prf_mask_t set_req;
  prf_pkg::prf_mask_t clear_req;

  // Decode the valid ports into per-register requests
  always_comb begin
    set_req = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      if (set_valid[i]) begin
        set_req[set_index[i]] = 1'b1;
      end
    end
  end

  always_comb begin
    clear_req = '0;
    for (int i = 0; i < `PRF_WAYS; i++) begin
      if (clear_valid[i]) begin
        clear_req[clear_index[i]] = 1'b1;
      end
    end
  end

  // Clear beats set on the same register
  always_comb begin
    busy_d    = (busy_q | set_req) & ~clear_req;
    // x0 is never busy
    busy_d[0] = 1'b0;
  end

  always_ff @(posedge clock) begin
    if (!rst_n || flush) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

  // Raw lookup from the state held at the start of the cycle
  always_comb begin
    for (int i = 0; i < `IQ_INT_SIZE; i++) begin
      rs1_int_table[i] = busy_q[rs1_int_index[i]];
      rs2_int_table[i] = busy_q[rs2_int_index[i]];
    end
    for (int i = 0; i < `IQ_MEM_SIZE; i++) begin
      rs1_mem_table[i] = busy_q[rs1_mem_index[i]];
      rs2_mem_table[i] = busy_q[rs2_mem_index[i]];
    end
  end

endmodule

/* hdl/iq_pkg.sv */
//////////////////////////////////////////////////
// Issue queue slot masks and operand index vectors
//////////////////////////////////////////////////
`include "prf_params.svh"

package iq_pkg;

  typedef logic [`IQ_INT_SIZE-1:0] int_slot_mask_t;
  typedef logic [`IQ_MEM_SIZE-1:0] mem_slot_mask_t;

  // One operand index for every slot
  typedef logic [`IQ_INT_SIZE-1:0][`PRF_INDEX_SIZE-1:0] int_index_vec_t;
  typedef logic [`IQ_MEM_SIZE-1:0][`PRF_INDEX_SIZE-1:0] mem_index_vec_t;

endpackage

/* hdl/operand_ready_merge.sv */
//////////////////////////////////////////////////
// Operand ready merge
// Table busy masked by bypass hits, then folded
// into per-slot ready bits for issue request
//////////////////////////////////////////////////
`timescale 1ns/1ns

module operand_ready_merge (
  input  iq_pkg::int_slot_mask_t rs1_int_table,
  input  iq_pkg::int_slot_mask_t rs2_int_table,
  input  iq_pkg::mem_slot_mask_t rs1_mem_table,
  input  iq_pkg::mem_slot_mask_t rs2_mem_table,
  input  iq_pkg::int_slot_mask_t rs1_int_hit,
  input  iq_pkg::int_slot_mask_t rs2_int_hit,
  input  iq_pkg::mem_slot_mask_t rs1_mem_hit,
  input  iq_pkg::mem_slot_mask_t rs2_mem_hit,
  output iq_pkg::int_slot_mask_t rs1_int_busy,
  output iq_pkg::int_slot_mask_t rs2_int_busy,
  output iq_pkg::mem_slot_mask_t rs1_mem_busy,
  output iq_pkg::mem_slot_mask_t rs2_mem_busy,
  output iq_pkg::int_slot_mask_t int_slot_ready,
  output iq_pkg::mem_slot_mask_t mem_slot_ready
);

  // Busy only if the table says so and no writeback arrives now
  assign rs1_int_busy = rs1_int_table & ~rs1_int_hit;
  assign rs2_int_busy = rs2_int_table & ~rs2_int_hit;
  assign rs1_mem_busy = rs1_mem_table & ~rs1_mem_hit;
  assign rs2_mem_busy = rs2_mem_table & ~rs2_mem_hit;

  // A slot can request issue once both sources are available
  assign int_slot_ready = ~(rs1_int_busy | rs2_int_busy);
  assign mem_slot_ready = ~(rs1_mem_busy | rs2_mem_busy);

endmodule

/* hdl/prf_pkg.sv */
//////////////////////////////////////////////////
// Physical register and busy table types
//////////////////////////////////////////////////
`include "prf_params.svh"

package prf_pkg;

  // One physical register index
  typedef logic [`PRF_INDEX_SIZE-1:0] prf_index_t;

  // One bit per physical register, table and request masks
  typedef logic [`PRF_SIZE-1:0] prf_mask_t;

  // One valid bit per writeback port
  typedef logic [`PRF_WAYS-1:0] wb_valid_t;

endpackage

/* hdl/prf_status_unit.sv */
//////////////////////////////////////////////////
// PRF status unit
// Busy table with writeback bypass, answering the
// operand queries of the int and mem issue queues
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "prf_params.svh"

module prf_status_unit (
  input  logic                                      clock,
  input  logic                                      rst_n,
  input  logic                                      flush,
  // Dispatch marks destinations busy
  input  prf_pkg::prf_index_t [`DISPATCH_WIDTH-1:0] set_index,
  input  logic [`DISPATCH_WIDTH-1:0]                set_valid,
  // Writeback marks results ready
  input  prf_pkg::prf_index_t [`PRF_WAYS-1:0]       clear_index,
  input  prf_pkg::wb_valid_t                        clear_valid,
  // Operand queries
  input  iq_pkg::int_index_vec_t                    rs1_int_index,
  input  iq_pkg::int_index_vec_t                    rs2_int_index,
  input  iq_pkg::mem_index_vec_t                    rs1_mem_index,
  input  iq_pkg::mem_index_vec_t                    rs2_mem_index,
  output iq_pkg::int_slot_mask_t                    rs1_int_busy,
  output iq_pkg::int_slot_mask_t                    rs2_int_busy,
  output iq_pkg::mem_slot_mask_t                    rs1_mem_busy,
  output iq_pkg::mem_slot_mask_t                    rs2_mem_busy,
  output iq_pkg::int_slot_mask_t                    int_slot_ready,
  output iq_pkg::mem_slot_mask_t                    mem_slot_ready
);

  iq_pkg::int_slot_mask_t rs1_int_table;
  iq_pkg::int_slot_mask_t rs2_int_table;
  iq_pkg::mem_slot_mask_t rs1_mem_table;
  iq_pkg::mem_slot_mask_t rs2_mem_table;

  iq_pkg::int_slot_mask_t rs1_int_hit;
  iq_pkg::int_slot_mask_t rs2_int_hit;
  iq_pkg::mem_slot_mask_t rs1_mem_hit;
  iq_pkg::mem_slot_mask_t rs2_mem_hit;

  busy_table i_busy_table (
    .clock         (clock),
    .rst_n         (rst_n),
    .flush         (flush),
    .set_index     (set_index),
    .set_valid     (set_valid),
    .clear_index   (clear_index),
    .clear_valid   (clear_valid),
    .rs1_int_index (rs1_int_index),
    .rs2_int_index (rs2_int_index),
    .rs1_mem_index (rs1_mem_index),
    .rs2_mem_index (rs2_mem_index),
    .rs1_int_table (rs1_int_table),
    .rs2_int_table (rs2_int_table),
    .rs1_mem_table (rs1_mem_table),
    .rs2_mem_table (rs2_mem_table)
  );

  wakeup_bypass i_wakeup_bypass (
    .clear_index   (clear_index),
    .clear_valid   (clear_valid),
    .rs1_int_index (rs1_int_index),
    .rs2_int_index (rs2_int_index),
    .rs1_mem_index (rs1_mem_index),
    .rs2_mem_index (rs2_mem_index),
    .rs1_int_hit   (rs1_int_hit),
    .rs2_int_hit   (rs2_int_hit),
    .rs1_mem_hit   (rs1_mem_hit),
    .rs2_mem_hit   (rs2_mem_hit)
  );

  operand_ready_merge i_operand_ready_merge (
    .rs1_int_table  (rs1_int_table),
    .rs2_int_table  (rs2_int_table),
    .rs1_mem_table  (rs1_mem_table),
    .rs2_mem_table  (rs2_mem_table),
    .rs1_int_hit    (rs1_int_hit),
    .rs2_int_hit    (rs2_int_hit),
    .rs1_mem_hit    (rs1_mem_hit),
    .rs2_mem_hit    (rs2_mem_hit),
    .rs1_int_busy   (rs1_int_busy),
    .rs2_int_busy   (rs2_int_busy),
    .rs1_mem_busy   (rs1_mem_busy),
    .rs2_mem_busy   (rs2_mem_busy),
    .int_slot_ready (int_slot_ready),
    .mem_slot_ready (mem_slot_ready)
  );

endmodule

/* hdl/wakeup_bypass.sv */
//////////////////////////////////////////////////
// Wakeup bypass
// Matches operand indexes against this cycle's
// writeback ports for same-cycle wakeup
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "prf_params.svh"

module wakeup_bypass (
  input  prf_pkg::prf_index_t [`PRF_WAYS-1:0] clear_index,
  input  prf_pkg::wb_valid_t                  clear_valid,
  input  iq_pkg::int_index_vec_t              rs1_int_index,
  input  iq_pkg::int_index_vec_t              rs2_int_index,
  input  iq_pkg::mem_index_vec_t              rs1_mem_index,
  input  iq_pkg::mem_index_vec_t              rs2_mem_index,
  output iq_pkg::int_slot_mask_t              rs1_int_hit,
  output iq_pkg::int_slot_mask_t              rs2_int_hit,
  output iq_pkg::mem_slot_mask_t              rs1_mem_hit,
  output iq_pkg::mem_slot_mask_t              rs2_mem_hit
);

  // True when any valid writeback port carries this index
  function automatic logic wb_match(
    input prf_pkg::prf_index_t                  idx,
    input prf_pkg::prf_index_t [`PRF_WAYS-1:0]  wb_index,
    input prf_pkg::wb_valid_t                   wb_valid
  );
    logic match;
    match = 1'b0;
    for (int w = 0; w < `PRF_WAYS; w++) begin
      if (wb_valid[w] && (wb_index[w] == idx)) begin
        match = 1'b1;
      end
    end
    return match;
  endfunction

  always_comb begin
    for (int i = 0; i < `IQ_INT_SIZE; i++) begin
      rs1_int_hit[i] = wb_match(rs1_int_index[i], clear_index, clear_valid);
      rs2_int_hit[i] = wb_match(rs2_int_index[i], clear_index, clear_valid);
    end
  end

  always_comb begin
    for (int i = 0; i < `IQ_MEM_SIZE; i++) begin
      rs1_mem_hit[i] = wb_match(rs1_mem_index[i], clear_index, clear_valid);
      rs2_mem_hit[i] = wb_match(rs2_mem_index[i], clear_index, clear_valid);
    end
  end

endmodule

/* include/prf_params.svh */
//////////////////////////////////////////////////
// PRF status unit sizes
// Register file, dispatch, writeback and issue slots
//////////////////////////////////////////////////
`ifndef PRF_PARAMS_SVH
`define PRF_PARAMS_SVH

// Physical register file
`define PRF_SIZE        64
`define PRF_INDEX_SIZE  6

// Set ports from dispatch, clear ports from writeback
`define DISPATCH_WIDTH  2
`define PRF_WAYS        2

// Issue queue slots that query operands
`define IQ_INT_SIZE     4
`define IQ_MEM_SIZE     2

`endif

/* project.f */
+incdir+include
hdl/prf_pkg.sv
hdl/iq_pkg.sv
hdl/busy_table.sv
hdl/wakeup_bypass.sv
hdl/operand_ready_merge.sv
hdl/prf_status_unit.sv
verif/prf_status_unit_assert.sv
verif/prf_status_unit_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the PRF status unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f project.f \
  --top-module prf_status_unit_tb \
  --Mdir "$BUILD_DIR" \
  -o prf_status_unit_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/prf_status_unit_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* verif/prf_status_unit_assert.sv */
//////////////////////////////////////////////////
// PRF status unit assertions
// Ready consistency, x0 and flush behavior
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "prf_params.svh"

module prf_status_unit_assert (
  input logic                   clock,
  input logic                   rst_n,
  input logic                   flush,
  input iq_pkg::int_index_vec_t rs1_int_index,
  input iq_pkg::int_index_vec_t rs2_int_index,
  input iq_pkg::mem_index_vec_t rs1_mem_index,
  input iq_pkg::mem_index_vec_t rs2_mem_index,
  input iq_pkg::int_slot_mask_t rs1_int_busy,
  input iq_pkg::int_slot_mask_t rs2_int_busy,
  input iq_pkg::mem_slot_mask_t rs1_mem_busy,
  input iq_pkg::mem_slot_mask_t rs2_mem_busy,
  input iq_pkg::int_slot_mask_t int_slot_ready,
  input iq_pkg::mem_slot_mask_t mem_slot_ready
);

  logic zero_busy;

  // Any operand that queries x0 and still reads busy
  always_comb begin
    zero_busy = 1'b0;
    for (int i = 0; i < `IQ_INT_SIZE; i++) begin
      zero_busy |= (rs1_int_index[i] == '0) && rs1_int_busy[i];
      zero_busy |= (rs2_int_index[i] == '0) && rs2_int_busy[i];
    end
    for (int i = 0; i < `IQ_MEM_SIZE; i++) begin
      zero_busy |= (rs1_mem_index[i] == '0) && rs1_mem_busy[i];
      zero_busy |= (rs2_mem_index[i] == '0) && rs2_mem_busy[i];
    end
  end

  ready_not_busy: assert property (@(posedge clock) disable iff (!rst_n)
    ((int_slot_ready & (rs1_int_busy | rs2_int_busy)) == '0) &&
    ((mem_slot_ready & (rs1_mem_busy | rs2_mem_busy)) == '0))
    else $error("slot ready while one of its operands is busy");

  x0_never_busy: assert property (@(posedge clock) disable iff (!rst_n) !zero_busy)
    else $error("physical register 0 reported busy");

  flush_empties: assert property (@(posedge clock) disable iff (!rst_n)
    flush |=> ((rs1_int_busy | rs2_int_busy) == '0) && ((rs1_mem_busy | rs2_mem_busy) == '0))
    else $error("operand still busy one cycle after flush");

endmodule

bind prf_status_unit prf_status_unit_assert i_prf_status_unit_assert (.*);

/* verif/prf_status_unit_tb.sv */
//////////////////////////////////////////////////
// PRF status unit testbench
// Directed table, then random traffic against a
// shadow busy model
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "prf_params.svh"

module prf_status_unit_tb;

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 8;
  localparam int RANDOM_CYCLES  = 200;
  // Reset, 24 table rows and the random phase, plus margin
  localparam int TIMEOUT_CYCLES = 300;

  typedef struct packed {
    prf_pkg::prf_index_t [`DISPATCH_WIDTH-1:0] set_idx;
    logic [`DISPATCH_WIDTH-1:0]                set_v;
    prf_pkg::prf_index_t [`PRF_WAYS-1:0]       clr_idx;
    prf_pkg::wb_valid_t                        clr_v;
    logic                                      fl;
    iq_pkg::int_index_vec_t                    query;
    logic [3:0]                                busy;
  } row_t;

  logic clock;
  logic rst_n;
  logic flush;
  prf_pkg::prf_index_t [`DISPATCH_WIDTH-1:0] set_index;
  logic [`DISPATCH_WIDTH-1:0]                set_valid;
  prf_pkg::prf_index_t [`PRF_WAYS-1:0]       clear_index;
  prf_pkg::wb_valid_t                        clear_valid;
  iq_pkg::int_index_vec_t rs1_int_index;
  iq_pkg::int_index_vec_t rs2_int_index;
  iq_pkg::mem_index_vec_t rs1_mem_index;
  iq_pkg::mem_index_vec_t rs2_mem_index;
  iq_pkg::int_slot_mask_t rs1_int_busy;
  iq_pkg::int_slot_mask_t rs2_int_busy;
  iq_pkg::mem_slot_mask_t rs1_mem_busy;
  iq_pkg::mem_slot_mask_t rs2_mem_busy;
  iq_pkg::int_slot_mask_t int_slot_ready;
  iq_pkg::mem_slot_mask_t mem_slot_ready;

  prf_pkg::prf_mask_t shadow;
  row_t rows[$];
  int   check_count = 0;
  int   error_count = 0;
  int   cycle_count = 0;

  prf_status_unit i_prf_status_unit (.*);

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  // Queried registers a..d, busy bits written as {d, c, b, a}
  task automatic add_row(input prf_pkg::prf_index_t s0, s1, input logic [1:0] sv,
                         input prf_pkg::prf_index_t c0, c1, input logic [1:0] cv,
                         input logic fl, input prf_pkg::prf_index_t qa, qb, qc, qd,
                         input logic [3:0] busy);
    row_t r;
    r.set_idx = {s1, s0};
    r.set_v   = sv;
    r.clr_idx = {c1, c0};
    r.clr_v   = cv;
    r.fl      = fl;
    r.query   = {qd, qc, qb, qa};
    r.busy    = busy;
    rows.push_back(r);
  endtask

  task automatic compare(input string name, input logic [7:0] expected, input logic [7:0] actual);
    check_count++;
    assert (actual === expected) else begin
      error_count++;
      $display("mismatch %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_outputs(input iq_pkg::int_slot_mask_t e1i, e2i,
                               input iq_pkg::mem_slot_mask_t e1m, e2m);
    iq_pkg::int_slot_mask_t int_ready;
    iq_pkg::mem_slot_mask_t mem_ready;
    // A slot is ready when neither source is busy
    for (int i = 0; i < `IQ_INT_SIZE; i++) begin
      int_ready[i] = !(e1i[i] || e2i[i]);
    end
    for (int i = 0; i < `IQ_MEM_SIZE; i++) begin
      mem_ready[i] = !(e1m[i] || e2m[i]);
    end
    compare("rs1_int_busy", 8'(e1i), 8'(rs1_int_busy));
    compare("rs2_int_busy", 8'(e2i), 8'(rs2_int_busy));
    compare("rs1_mem_busy", 8'(e1m), 8'(rs1_mem_busy));
    compare("rs2_mem_busy", 8'(e2m), 8'(rs2_mem_busy));
    compare("int_slot_ready", 8'(int_ready), 8'(int_slot_ready));
    compare("mem_slot_ready", 8'(mem_ready), 8'(mem_slot_ready));
  endtask

  // Table state plus this cycle's writeback forwarding
  function automatic logic model_busy(input prf_pkg::prf_index_t idx);
    logic hit;
    hit = 1'b0;
    for (int w = 0; w < `PRF_WAYS; w++) begin
      if (clear_valid[w] && (clear_index[w] == idx)) begin
        hit = 1'b1;
      end
    end
    return shadow[idx] && !hit;
  endfunction

  task automatic update_shadow();
    if (flush) begin
      shadow = '0;
    end else begin
      for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        if (set_valid[i]) shadow[set_index[i]] = 1'b1;
      end
      // Clear wins over a set of the same register
      for (int i = 0; i < `PRF_WAYS; i++) begin
        if (clear_valid[i]) shadow[clear_index[i]] = 1'b0;
      end
    end
    shadow[0] = 1'b0;
  endtask

  function automatic prf_pkg::prf_index_t rand_index();
    return prf_pkg::prf_index_t'($urandom_range(15, 0));
  endfunction

  initial begin
    iq_pkg::int_slot_mask_t e1i;
    iq_pkg::int_slot_mask_t e2i;
    iq_pkg::mem_slot_mask_t e1m;
    iq_pkg::mem_slot_mask_t e2m;
    logic [3:0]             e;
    void'($urandom(32'hd41b));
    rst_n = 1'b0;
    flush = 1'b0;
    set_index = '0;
    set_valid = '0;
    clear_index = '0;
    clear_valid = '0;
    rs1_int_index = '0;
    rs2_int_index = '0;
    rs1_mem_index = '0;
    rs2_mem_index = '0;
    shadow = '0;
    //      s0  s1  sv     c0  c1  cv     fl    a   b   c   d   busy
    add_row( 0,  0, 2'b00,  0,  0, 2'b00, 1'b0,  1,  2,  3,  4, 4'b0000);
    add_row( 5,  6, 2'b11,  0,  0, 2'b00, 1'b0,  5,  6,  7,  0, 4'b0000);
    add_row( 0,  0, 2'b00,  0,  0, 2'b00, 1'b0,  5,  6,  7,  0, 4'b0011);
    add_row( 7,  0, 2'b01,  0,  0, 2'b00, 1'b0,  5,  6,  7,  0, 4'b0011);
    add_row( 0,  0, 2'b00,  5,  0, 2'b01, 1'b0,  5,  6,  7,  0, 4'b0110);
    add_row( 0,  0, 2'b00,  0,  0, 2'b00, 1'b0,  5,  6,  7,  0, 4'b0110);
    add_row( 0,  0, 2'b00,  6,  7, 2'b11, 1'b0,  6,  7,  5,  0, 4'b0000);
    add_row( 0,  0, 2'b00,  0,  0, 2'b00, 1'b0,  6,  7,  5,  0, 4'b0000);
    add_row( 9,  0, 2'b11,  9,  0, 2'b01, 1'b0,  9,  0,  1,  2, 4'b0000);
    add_row( 0,  0, 2'b00,  0,  0, 2'b00, 1'b0,  9,  0,  1,  2, 4'b0000);
    add_row(10, 11, 2'b11,  0,  0, 2'b00, 1'b0, 10, 11,  0,  9, 4'b0000);
    add_row(12, 13, 2'b11,  0,  0, 2'b00, 1'b0, 10, 11, 12, 13, 4'b0011);
    add_row(14, 15, 2'b11,  0,  0, 2'b00, 1'b0, 10, 11, 12, 13, 4'b1111);
    add_row(20, 21, 2'b11,  0,  0, 2'b00, 1'b1, 10, 11, 14, 15, 4'b1111);
    add_row( 0,  0, 2'b00,  0,  0, 2'b00, 1'b0, 10, 11, 14, 15, 4'b0000);
    add_row( 0,  0, 2'b00,  0,  0, 2'b00, 1'b0, 20, 21, 12, 13, 4'b0000);
    add_row(30,  0, 2'b01,  0, 31, 2'b10, 1'b0, 30, 31,  0,  0, 4'b0000);
    add_row( 0, 31, 2'b10,  0,  0, 2'b00, 1'b0, 30, 31,  0,  0, 4'b0001);
    add_row( 0,  0, 2'b00,  0, 30, 2'b10, 1'b0, 30, 31,  0,  0, 4'b0010);
    add_row(40, 41, 2'b11,  0,  0, 2'b00, 1'b0, 31, 30, 40, 41, 4'b0001);
    add_row( 0,  0, 2'b00, 31, 40, 2'b11, 1'b0, 31, 40, 41,  0, 4'b0100);
    add_row( 0,  0, 2'b00,  0,  0, 2'b00, 1'b0, 31, 40, 41,  0, 4'b0100);
    add_row(63, 62, 2'b11,  0,  0, 2'b00, 1'b0, 63, 62, 41,  0, 4'b0100);
    add_row( 0,  0, 2'b00, 41,  0, 2'b01, 1'b0, 63, 62, 41,  0, 4'b0011);

    repeat (RESET_CYCLES) @(posedge clock);
    rst_n <= 1'b1;

    foreach (rows[n]) begin
      @(posedge clock);
      set_index     <= rows[n].set_idx;
      set_valid     <= rows[n].set_v;
      clear_index   <= rows[n].clr_idx;
      clear_valid   <= rows[n].clr_v;
      flush         <= rows[n].fl;
      rs1_int_index <= rows[n].query;
      rs2_int_index <= {rows[n].query[0], rows[n].query[3], rows[n].query[2], rows[n].query[1]};
      rs1_mem_index <= {rows[n].query[3], rows[n].query[2]};
      rs2_mem_index <= {rows[n].query[0], rows[n].query[3]};
      #(CLK_PERIOD - 10);
      e = rows[n].busy;
      check_outputs(e, {e[0], e[3], e[2], e[1]}, {e[3], e[2]}, {e[0], e[3]});
      update_shadow();
    end

    // Small index range so sets, clears and queries collide often
    repeat (RANDOM_CYCLES) begin
      @(posedge clock);
      flush       <= ($urandom_range(31, 0) == 0);
      set_valid   <= 2'($urandom);
      clear_valid <= 2'($urandom);
      for (int i = 0; i < `DISPATCH_WIDTH; i++) set_index[i] <= rand_index();
      for (int i = 0; i < `PRF_WAYS; i++) clear_index[i] <= rand_index();
      for (int i = 0; i < `IQ_INT_SIZE; i++) begin
        rs1_int_index[i] <= rand_index();
        rs2_int_index[i] <= rand_index();
      end
      for (int i = 0; i < `IQ_MEM_SIZE; i++) begin
        rs1_mem_index[i] <= rand_index();
        rs2_mem_index[i] <= rand_index();
      end
      #(CLK_PERIOD - 10);
      for (int i = 0; i < `IQ_INT_SIZE; i++) begin
        e1i[i] = model_busy(rs1_int_index[i]);
        e2i[i] = model_busy(rs2_int_index[i]);
      end
      for (int i = 0; i < `IQ_MEM_SIZE; i++) begin
        e1m[i] = model_busy(rs1_mem_index[i]);
        e2m[i] = model_busy(rs2_mem_index[i]);
      end
      check_outputs(e1i, e2i, e1m, e2m);
      update_shadow();
    end

    $display("checks %0d errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
